// File: files.f
wired_pkg.sv
wired_iq_entry_static.sv
wired_iq_entry_data.sv
wired_iq_entry.sv
wired_iq_dispatch.sv
wired_iq_select.sv
wired_iq.sv
tb_wired_iq.sv

// File: Bender.yml
package:
  name: wired_iq

sources:
  - wired_pkg.sv
  - wired_iq_entry_static.sv
  - wired_iq_entry_data.sv
  - wired_iq_entry.sv
  - wired_iq_dispatch.sv
  - wired_iq_select.sv
  - wired_iq.sv
  - target: test
    files:
      - tb_wired_iq.sv

// File: tb_wired_iq.sv
`timescale 1ns/10ps
`default_nettype none

module tb_wired_iq;

  localparam int N_INST     = 40;
  localparam int KIND_READY = 0;  // value given at dispatch
  localparam int KIND_WAIT  = 1;  // value comes over the cdb
  localparam int KIND_MASK  = 2;  // operand not needed
  localparam int NR         = wired_pkg::RREG_CNT;

  logic                                           clk = 1'b0;
  logic                                           rst_n_i;
  logic                                           disp_valid_i;
  logic                                           disp_ready_o;
  wired_pkg::payload_t                            disp_payload_i;
  logic                [NR-1:0]                   disp_op_valid_i;
  wired_pkg::rob_rid_t [NR-1:0]                   disp_op_rid_i;
  wired_pkg::word_t    [NR-1:0]                   disp_op_data_i;
  logic                [NR-1:0]                   disp_op_mask_i;
  logic                [wired_pkg::CDB_COUNT-1:0] cdb_valid_i;
  wired_pkg::rob_rid_t [wired_pkg::CDB_COUNT-1:0] cdb_rid_i;
  wired_pkg::word_t    [wired_pkg::CDB_COUNT-1:0] cdb_data_i;
  logic                                           issue_valid_o;
  logic                                           issue_ready_i;
  wired_pkg::word_t    [NR-1:0]                   issue_data_o;
  wired_pkg::payload_t                            issue_payload_o;

  // scoreboard, indexed by sequence number
  wired_pkg::payload_t pay_rec [N_INST];
  int                  kind_rec [N_INST][NR];
  wired_pkg::word_t    data_rec [N_INST][NR];
  wired_pkg::word_t    bc_val [N_INST][NR];
  bit                  bc_done [N_INST][NR];
  bit                  issued [N_INST];
  int                  pend_seq[$];
  int                  pend_op[$];
  int                  pend_due[$];

  logic [31:0]                 rng_state;
  int                          cyc;
  int                          disp_cnt;
  int                          issue_cnt;
  int                          errors;
  bit                          rand_ready;
  bit                          stalled;
  wired_pkg::payload_t         held_pay;
  wired_pkg::word_t [NR-1:0]   held_data;
  bit                          ok;

  wired_iq UUT (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic wired_pkg::rob_rid_t tag_for(int s, int k);
    return wired_pkg::rob_rid_t'((2 * s + k) % (1 << wired_pkg::RID_W));
  endfunction

  // expected operand value for an issued instruction
  function automatic wired_pkg::word_t expected_operand(int s, int k);
    if (kind_rec[s][k] == KIND_READY) begin
      return data_rec[s][k];
    end
    return bc_val[s][k];  // waiting operand carries the broadcast value
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // up to two due broadcasts per cycle, port order picked at random
  task automatic drive_cdb();
    int i;
    int n;
    int p;
    int s;
    int k;
    cdb_valid_i = '0;
    i = 0;
    n = 0;
    p = next_random() % 2;
    while (i < pend_seq.size()) begin
      if (n < 2 && pend_due[i] <= cyc) begin
        s = pend_seq[i];
        k = pend_op[i];
        bc_val[s][k]   = next_random();
        bc_done[s][k]  = 1'b1;
        cdb_valid_i[p] = 1'b1;
        cdb_rid_i[p]   = tag_for(s, k);
        cdb_data_i[p]  = bc_val[s][k];
        p = 1 - p;
        n++;
        pend_seq.delete(i);
        pend_op.delete(i);
        pend_due.delete(i);
      end else begin
        i++;
      end
    end
  endtask

  // mode 0 any kind, 1 no waiting operand, 2 waits on tags never broadcast
  task automatic cycle_step(input bit try_disp, input int mode, output bit done);
    int          s;
    logic [31:0] r;
    @(posedge clk);
    #2;
    cyc++;
    done         = 1'b0;
    disp_valid_i = 1'b0;
    if (rand_ready) issue_ready_i = (next_random() % 4) != 0;
    if (try_disp && disp_ready_o) begin  // ready only depends on entry state
      s = disp_cnt;
      r = next_random();
      pay_rec[s] = {r[7:0], 8'(s)};
      for (int k = 0; k < NR; k++) begin
        if (mode == 1) kind_rec[s][k] = (next_random() % 2) ? KIND_READY : KIND_MASK;
        else if (mode == 2) kind_rec[s][k] = KIND_WAIT;
        else kind_rec[s][k] = next_random() % 3;
        data_rec[s][k]     = next_random();
        disp_op_valid_i[k] = kind_rec[s][k] == KIND_READY;
        disp_op_mask_i[k]  = kind_rec[s][k] == KIND_MASK;
        disp_op_rid_i[k]   = tag_for(s, k);
        disp_op_data_i[k]  = (kind_rec[s][k] == KIND_WAIT) ? next_random() : data_rec[s][k];
        if (kind_rec[s][k] == KIND_WAIT && mode != 2) begin
          pend_seq.push_back(s);
          pend_op.push_back(k);
          pend_due.push_back(cyc + int'(next_random() % 5));  // 0 means same cycle
        end
      end
      disp_payload_i = pay_rec[s];
      disp_valid_i   = 1'b1;
      disp_cnt++;
      done = 1'b1;
    end
    drive_cdb();
  endtask

  task automatic dispatch_one(input int mode);
    bit done;
    do cycle_step(1'b1, mode, done); while (!done);
  endtask

  // taken issues and the stalled offer, sampled mid-cycle
  always @(negedge clk) begin : compare_issue
    int s;
    if (rst_n_i) begin
      if (stalled) begin
        check_val("issue_valid_o", 1, issue_valid_o);
        check_val("issue_payload_o", held_pay, issue_payload_o);
        for (int k = 0; k < NR; k++) begin
          check_val($sformatf("issue_data_o[%0d]", k), held_data[k], issue_data_o[k]);
        end
      end
      stalled   = issue_valid_o && !issue_ready_i;
      held_pay  = issue_payload_o;
      held_data = issue_data_o;
      if (issue_valid_o && issue_ready_i) begin
        s = issue_payload_o[7:0];
        if (s >= disp_cnt) begin
          errors++;
          $display("unknown sequence number %0d issued at %0t", s, $time);
        end else if (issued[s]) begin
          errors++;
          $display("instruction %0d issued a second time at %0t", s, $time);
        end else begin
          issued[s] = 1'b1;
          issue_cnt++;
          check_val("issue_payload_o", pay_rec[s], issue_payload_o);
          for (int k = 0; k < NR; k++) begin
            if (kind_rec[s][k] == KIND_WAIT && !bc_done[s][k]) begin
              errors++;
              $display("instruction %0d issued before its tag was broadcast at %0t", s, $time);
            end else if (kind_rec[s][k] != KIND_MASK) begin
              check_val($sformatf("issue_data_o[%0d]", k), expected_operand(s, k),
                        issue_data_o[k]);
            end
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (N_INST * 60) @(posedge clk);
    $display("timeout after %0d cycles, the run did not complete", N_INST * 60);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rng_state       = 32'h1557;
    cyc             = 0;
    disp_cnt        = 0;
    issue_cnt       = 0;
    errors          = 0;
    rand_ready      = 1'b0;
    stalled         = 1'b0;
    rst_n_i         = 1'b0;
    disp_valid_i    = 1'b0;
    disp_payload_i  = '0;
    disp_op_valid_i = '0;
    disp_op_rid_i   = '0;
    disp_op_data_i  = '0;
    disp_op_mask_i  = '0;
    cdb_valid_i     = '0;
    cdb_rid_i       = '0;
    cdb_data_i      = '0;
    issue_ready_i   = 1'b0;
    repeat (4) @(posedge clk);
    #2 rst_n_i = 1'b1;
    cycle_step(1'b0, 0, ok);
    check_val("issue_valid_o", 0, issue_valid_o);
    check_val("disp_ready_o", 1, disp_ready_o);
    // fill all four entries while the consumer stalls
    repeat (4) dispatch_one(1);
    cycle_step(1'b0, 0, ok);
    check_val("disp_ready_o", 0, disp_ready_o);
    repeat (3) cycle_step(1'b0, 0, ok);
    issue_ready_i = 1'b1;
    cycle_step(1'b0, 0, ok);
    check_val("disp_ready_o", 1, disp_ready_o);  // one slot freed
    rand_ready = 1'b1;
    while (disp_cnt < N_INST - 1) begin
      repeat (next_random() % 3) cycle_step(1'b0, 0, ok);
      dispatch_one(0);
    end
    while (issue_cnt < disp_cnt || pend_seq.size() > 0) cycle_step(1'b0, 0, ok);
    dispatch_one(2);
    repeat (20) cycle_step(1'b0, 0, ok);
    check_val("issue_valid_o", 0, issue_valid_o);
    for (int s = 0; s < N_INST - 1; s++) begin
      if (!issued[s]) begin
        errors++;
        $display("instruction %0d was never issued", s);
      end
    end
    if (issued[N_INST - 1]) begin
      errors++;
      $display("instruction %0d issued although its tags were never broadcast", N_INST - 1);
    end
    $display("%0d errors, %0d of %0d instructions issued", errors, issue_cnt, disp_cnt);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: wired_iq.sv
`timescale 1ns/10ps
`default_nettype none

module wired_iq (
  input  logic                                             clk,
  input  logic                                             rst_n_i,
  // dispatch side
  input  logic                                             disp_valid_i,
  output logic                                             disp_ready_o,
  input  wired_pkg::payload_t                              disp_payload_i,
  input  logic                [wired_pkg::RREG_CNT-1:0]    disp_op_valid_i,
  input  wired_pkg::rob_rid_t [wired_pkg::RREG_CNT-1:0]    disp_op_rid_i,
  input  wired_pkg::word_t    [wired_pkg::RREG_CNT-1:0]    disp_op_data_i,
  input  logic                [wired_pkg::RREG_CNT-1:0]    disp_op_mask_i,
  // result broadcast
  input  logic                [wired_pkg::CDB_COUNT-1:0]   cdb_valid_i,
  input  wired_pkg::rob_rid_t [wired_pkg::CDB_COUNT-1:0]   cdb_rid_i,
  input  wired_pkg::word_t    [wired_pkg::CDB_COUNT-1:0]   cdb_data_i,
  // issue side
  output logic                                             issue_valid_o,
  input  logic                                             issue_ready_i,
  output wired_pkg::word_t    [wired_pkg::RREG_CNT-1:0]    issue_data_o,
  output wired_pkg::payload_t                              issue_payload_o
);

  logic [wired_pkg::IQ_DEPTH-1:0] alloc;
  logic [wired_pkg::IQ_DEPTH-1:0] sel;
  logic [wired_pkg::IQ_DEPTH-1:0] entry_empty;
  logic [wired_pkg::IQ_DEPTH-1:0] entry_ready;

  wired_pkg::word_t [wired_pkg::IQ_DEPTH-1:0][wired_pkg::RREG_CNT-1:0] entry_data;
  wired_pkg::payload_t [wired_pkg::IQ_DEPTH-1:0]                      entry_payload;

  wired_iq_dispatch u_dispatch (
    .disp_valid_i  (disp_valid_i),
    .entry_empty_i (entry_empty),
    .disp_ready_o  (disp_ready_o),
    .alloc_o       (alloc)
  );

  // dispatch fields fan out, alloc picks the slot
  for (genvar e = 0; e < wired_pkg::IQ_DEPTH; e++) begin : g_entry
    wired_iq_entry u_entry (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .sel_i       (sel[e]),
      .updata_i    (alloc[e]),
      .payload_i   (disp_payload_i),
      .op_valid_i  (disp_op_valid_i),
      .op_rid_i    (disp_op_rid_i),
      .op_data_i   (disp_op_data_i),
      .op_mask_i   (disp_op_mask_i),
      .cdb_valid_i (cdb_valid_i),
      .cdb_rid_i   (cdb_rid_i),
      .cdb_data_i  (cdb_data_i),
      .empty_o     (entry_empty[e]),
      .ready_o     (entry_ready[e]),
      .data_o      (entry_data[e]),
      .payload_o   (entry_payload[e])
    );
  end

  wired_iq_select u_select (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .entry_ready_i   (entry_ready),
    .entry_data_i    (entry_data),
    .entry_payload_i (entry_payload),
    .issue_ready_i   (issue_ready_i),
    .issue_valid_o   (issue_valid_o),
    .issue_data_o    (issue_data_o),
    .issue_payload_o (issue_payload_o),
    .sel_o           (sel)
  );

endmodule

`default_nettype wire

// File: wired_iq_select.sv
`timescale 1ns/10ps
`default_nettype none

module wired_iq_select (
  input  logic                                                         clk,
  input  logic                                                         rst_n_i,
  input  logic             [wired_pkg::IQ_DEPTH-1:0]                   entry_ready_i,
  input  wired_pkg::word_t [wired_pkg::IQ_DEPTH-1:0][wired_pkg::RREG_CNT-1:0] entry_data_i,
  input  wired_pkg::payload_t [wired_pkg::IQ_DEPTH-1:0]                entry_payload_i,
  input  logic                                                         issue_ready_i,
  output logic                                                         issue_valid_o,
  output wired_pkg::word_t [wired_pkg::RREG_CNT-1:0]                   issue_data_o,
  output wired_pkg::payload_t                                          issue_payload_o,
  output logic             [wired_pkg::IQ_DEPTH-1:0]                   sel_o
);

  logic [wired_pkg::IQ_DEPTH-1:0] first_ready;
  logic                           any_ready;
  logic [wired_pkg::IQ_DEPTH-1:0] chosen;   // one-hot
  logic [wired_pkg::IQ_DEPTH-1:0] held_q;
  logic                           hold_q;   // port stalled last cycle

  always_comb begin
    first_ready = '0;
    any_ready   = 1'b0;
    for (int i = 0; i < wired_pkg::IQ_DEPTH; i++) begin
      if (entry_ready_i[i] && !any_ready) begin
        first_ready[i] = 1'b1;
        any_ready      = 1'b1;
      end
    end
  end

  // stick with the offered entry until the consumer takes it
  assign chosen = hold_q ? held_q : first_ready;

  assign issue_valid_o = |chosen;
  assign sel_o         = issue_ready_i ? chosen : '0;

  always_comb begin
    issue_data_o    = '0;
    issue_payload_o = '0;
    for (int i = 0; i < wired_pkg::IQ_DEPTH; i++) begin
      if (chosen[i]) begin
        issue_data_o    = issue_data_o | entry_data_i[i];
        issue_payload_o = issue_payload_o | entry_payload_i[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= issue_valid_o && !issue_ready_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid_o && !issue_ready_i) begin
      held_q <= chosen;
    end
  end

  // the strobe hits at most one entry, and that entry must still be ready
  a_sel_onehot: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    $onehot0(sel_o) && ((sel_o & ~entry_ready_i) == '0)
  ) else $error("bad issue strobe %b, ready %b", sel_o, entry_ready_i);

  // stalled offer must not move
  a_issue_stable: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (issue_valid_o && !issue_ready_i) |=>
      (issue_valid_o && $stable(issue_payload_o) && $stable(issue_data_o))
  ) else $error("issue port changed under back-pressure");

endmodule

`default_nettype wire

// File: wired_iq_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module wired_iq_dispatch (
  input  logic                           disp_valid_i,
  input  logic [wired_pkg::IQ_DEPTH-1:0] entry_empty_i,
  output logic                           disp_ready_o,
  output logic [wired_pkg::IQ_DEPTH-1:0] alloc_o
);

  logic [wired_pkg::IQ_DEPTH-1:0] first_free;
  logic                           found;

  // lowest free slot wins
  always_comb begin
    first_free = '0;
    found      = 1'b0;
    for (int i = 0; i < wired_pkg::IQ_DEPTH; i++) begin
      if (entry_empty_i[i] && !found) begin
        first_free[i] = 1'b1;
        found         = 1'b1;
      end
    end
  end

  // ready as long as any slot is free
  assign disp_ready_o = found;

  // strobe only on an accepted handshake
  assign alloc_o = (disp_valid_i && disp_ready_o) ? first_free : '0;

endmodule

`default_nettype wire

// File: wired_iq_entry.sv
`timescale 1ns/10ps
`default_nettype none

module wired_iq_entry (
  input  logic                                             clk,
  input  logic                                             rst_n_i,
  input  logic                                             sel_i,
  input  logic                                             updata_i,
  input  wired_pkg::payload_t                              payload_i,
  input  logic                [wired_pkg::RREG_CNT-1:0]    op_valid_i,
  input  wired_pkg::rob_rid_t [wired_pkg::RREG_CNT-1:0]    op_rid_i,
  input  wired_pkg::word_t    [wired_pkg::RREG_CNT-1:0]    op_data_i,
  input  logic                [wired_pkg::RREG_CNT-1:0]    op_mask_i,
  input  logic                [wired_pkg::CDB_COUNT-1:0]   cdb_valid_i,
  input  wired_pkg::rob_rid_t [wired_pkg::CDB_COUNT-1:0]   cdb_rid_i,
  input  wired_pkg::word_t    [wired_pkg::CDB_COUNT-1:0]   cdb_data_i,
  output logic                                             empty_o,
  output logic                                             ready_o,
  output wired_pkg::word_t    [wired_pkg::RREG_CNT-1:0]    data_o,
  output wired_pkg::payload_t                              payload_o
);

  logic                           valid_inst;
  logic [wired_pkg::RREG_CNT-1:0] value_ready;
  logic [wired_pkg::RREG_CNT-1:0] mask_q;
  logic                           ready_q;

  wired_iq_entry_static u_static (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .sel_i        (sel_i),
    .updata_i     (updata_i),
    .payload_i    (payload_i),
    .payload_o    (payload_o),
    .valid_inst_o (valid_inst),
    .empty_o      (empty_o)
  );

  // one capture slice per source operand
  for (genvar i = 0; i < wired_pkg::RREG_CNT; i++) begin : g_op
    wired_iq_entry_data u_data (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .sel_i         (sel_i),
      .updata_i      (updata_i),
      .valid_inst_i  (valid_inst),
      .data_valid_i  (op_valid_i[i] | op_mask_i[i]),  // masked slot never snoops
      .data_rid_i    (op_rid_i[i]),
      .data_i        (op_data_i[i]),
      .cdb_valid_i   (cdb_valid_i),
      .cdb_rid_i     (cdb_rid_i),
      .cdb_data_i    (cdb_data_i),
      .value_ready_o (value_ready[i]),
      .data_o        (data_o[i])
    );
  end

  always_ff @(posedge clk) begin
    if (updata_i) begin
      mask_q <= op_mask_i;
    end
  end

  // registered ready, one edge behind the last operand
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else if (sel_i) begin
      ready_q <= 1'b0;  // otherwise it would linger one cycle and reissue
    end else begin
      ready_q <= valid_inst && (&(value_ready | mask_q));
    end
  end

  assign ready_o = ready_q;

endmodule

`default_nettype wire

// File: wired_iq_entry_data.sv
`timescale 1ns/10ps
`default_nettype none

module wired_iq_entry_data (
  input  logic                                              clk,
  input  logic                                              rst_n_i,
  input  logic                                              sel_i,
  input  logic                                              updata_i,
  input  logic                                              valid_inst_i,
  input  logic                                              data_valid_i,
  input  wired_pkg::rob_rid_t                               data_rid_i,
  input  wired_pkg::word_t                                  data_i,
  input  logic                [wired_pkg::CDB_COUNT-1:0]    cdb_valid_i,
  input  wired_pkg::rob_rid_t [wired_pkg::CDB_COUNT-1:0]    cdb_rid_i,
  input  wired_pkg::word_t    [wired_pkg::CDB_COUNT-1:0]    cdb_data_i,
  output logic                                              value_ready_o,
  output wired_pkg::word_t                                  data_o
);

  wired_pkg::rob_rid_t rid_q;
  wired_pkg::word_t    data_q;
  logic                ready_q;

  logic [wired_pkg::CDB_COUNT-1:0] hit_new;  // against the incoming tag
  logic [wired_pkg::CDB_COUNT-1:0] hit_old;  // against the stored tag
  logic [wired_pkg::CDB_COUNT-1:0] hit;
  wired_pkg::word_t                cdb_word;
  logic                            capture;

  always_comb begin
    hit_new = '0;
    hit_old = '0;
    for (int i = 0; i < wired_pkg::CDB_COUNT; i++) begin
      hit_new[i] = cdb_valid_i[i] && (cdb_rid_i[i] == data_rid_i);
      hit_old[i] = cdb_valid_i[i] && (cdb_rid_i[i] == rid_q);
    end
  end

  // on allocate the stored tag is not there yet, so forward from the new one
  assign hit = updata_i ? hit_new : hit_old;

  // at most one port hits, an or-mux is enough
  always_comb begin
    cdb_word = '0;
    for (int i = 0; i < wired_pkg::CDB_COUNT; i++) begin
      if (hit[i]) begin
        cdb_word = cdb_word | cdb_data_i[i];
      end
    end
  end

  assign capture = valid_inst_i && !ready_q && (|hit_old);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else if (updata_i) begin
      ready_q <= data_valid_i | (|hit_new);
    end else if (sel_i) begin
      ready_q <= 1'b0;
    end else if (capture) begin
      ready_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (updata_i) begin
      rid_q  <= data_rid_i;
      data_q <= data_valid_i ? data_i : cdb_word;
    end else if (capture) begin
      data_q <= cdb_word;  // late wakeup
    end
  end

  assign value_ready_o = ready_q;
  assign data_o        = data_q;

  // a tag is produced once, so two ports never carry it together
  a_cdb_single_hit: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    ((updata_i && !data_valid_i) || (valid_inst_i && !ready_q)) |-> $onehot0(hit)
  ) else $error("tag matched on more than one cdb port");

endmodule

`default_nettype wire

// File: wired_iq_entry_static.sv
`timescale 1ns/10ps
`default_nettype none

module wired_iq_entry_static (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                sel_i,     // entry leaves on this edge
  input  logic                updata_i,  // new instruction written
  input  wired_pkg::payload_t payload_i,
  output wired_pkg::payload_t payload_o,
  output logic                valid_inst_o,
  output logic                empty_o
);

  logic                valid_q;
  wired_pkg::payload_t payload_q;

  // occupancy flag
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (updata_i) begin
      valid_q <= 1'b1;
    end else if (sel_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (updata_i) begin
      payload_q <= payload_i;  // only loaded on allocate
    end
  end

  assign payload_o    = payload_q;
  assign valid_inst_o = valid_q;
  assign empty_o      = ~valid_q;

  // dispatch must only pick a free slot
  a_alloc_free: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    updata_i |-> !valid_q
  ) else $error("entry allocated while still holding an instruction");

endmodule

`default_nettype wire

// File: wired_pkg.sv
`default_nettype none

package wired_pkg;

  // queue geometry
  localparam int IQ_DEPTH  = 4;
  localparam int RREG_CNT  = 2;  // source operands per instruction
  localparam int CDB_COUNT = 2;  // broadcast ports watched by every entry

  // rob tag width
  localparam int RID_W = 5;

  localparam int WORD_W    = 32;
  localparam int PAYLOAD_W = 16;

  typedef logic [RID_W-1:0] rob_rid_t;

  // operand value as carried on the cdb
  typedef logic [WORD_W-1:0] word_t;

  // control bits that ride along with the instruction
  typedef logic [PAYLOAD_W-1:0] payload_t;

endpackage

`default_nettype wire
